//--- design/fetch_pc_gen.sv
// ****************************************
// program counter, fetch packet and trap vectoring
// ****************************************
module fetch_pc_gen (
    input  logic                            clk,
    input  logic                            reset,

    // from the configuration block
    input  logic                            fetch_en_i,
    input  logic [frontend_pkg::XLEN-1:0]   tvec_i,
    input  logic                            irq_pend_i,
    input  logic [frontend_pkg::IRQ_NO_W-1:0] irq_pend_no_i,

    // back end redirect
    input  logic                            redirect_i,
    input  logic [frontend_pkg::XLEN-1:0]   redirect_pc_i,

    // instruction memory
    output logic [frontend_pkg::IMEM_AW-1:0] imem_addr_o,
    input  logic [frontend_pkg::XLEN-1:0]   instr_i,

    // towards IF/ID
    output logic                            fetch_valid_o,
    input  logic                            fetch_ready_i,
    output frontend_pkg::fetch_pkt_t        fetch_pkt_o,
    output logic                            irq_take_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            fetch_fire;
    logic [XLEN-1:0] trap_pc;

    // word address into the memory
    assign imem_addr_o = pc_q[IMEM_AW+1:2];

    assign fetch_valid_o = fetch_en_i;

    // a fetch offered during a redirect is dropped by the flush
    assign fetch_fire = fetch_valid_o && fetch_ready_i && !redirect_i;

    // vector target is base + 4 * irq number
    assign trap_pc = tvec_i + {{(XLEN-IRQ_NO_W-2){1'b0}}, irq_pend_no_i, 2'b00};

    assign irq_take_o = fetch_fire && irq_pend_i;

    always_comb begin
        fetch_pkt_o.pc     = pc_q;
        fetch_pkt_o.instr  = instr_i;
        fetch_pkt_o.irq    = irq_pend_i;
        fetch_pkt_o.irq_no = irq_pend_i ? irq_pend_no_i : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_fire) begin
            if (irq_pend_i) begin
                pc_q <= trap_pc;
            end else begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

endmodule

//--- design/frontend_pkg.sv
// ****************************************
// shared widths, addresses, opcodes and payload types of the front end
// ****************************************
package frontend_pkg;

    // data path and interrupt widths
    localparam int XLEN     = 32;
    localparam int IRQ_NO_W = 8;

    // instruction memory geometry
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // configuration register map
    localparam int             CFG_AW        = 2;
    localparam logic [CFG_AW-1:0] CFG_ADDR_CTRL = 2'd0;
    localparam logic [CFG_AW-1:0] CFG_ADDR_TVEC = 2'd1;

    // CTRL register bit positions
    localparam int CTRL_FETCH_EN_BIT = 0;
    localparam int CTRL_IRQ_EN_BIT   = 1;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_ALUI,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JUMP,
        OP_UPPER,
        OP_ILLEGAL
    } op_class_e;

    // IF/ID payload
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     instr;
        logic                irq;
        logic [IRQ_NO_W-1:0] irq_no;
    } fetch_pkt_t;

    // ID/OUT payload
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        op_class_e           op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [XLEN-1:0]     imm;
        logic                irq;
        logic [IRQ_NO_W-1:0] irq_no;
    } decoded_t;

endpackage

//--- design/frontend_top.sv
// ****************************************
// instruction front end: config, fetch, memory, IF/ID, decode, ID/OUT
// ****************************************
module frontend_top (
    input  logic                              clk,
    input  logic                              reset,

    // configuration writes
    input  logic                              cfg_we_i,
    input  logic [frontend_pkg::CFG_AW-1:0]   cfg_addr_i,
    input  logic [frontend_pkg::XLEN-1:0]     cfg_wdata_i,

    // instruction memory load
    input  logic                              imem_we_i,
    input  logic [frontend_pkg::IMEM_AW-1:0]  imem_addr_i,
    input  logic [frontend_pkg::XLEN-1:0]     imem_wdata_i,

    // interrupt and redirect
    input  logic                              irq_i,
    input  logic [frontend_pkg::IRQ_NO_W-1:0] irq_no_i,
    input  logic                              redirect_i,
    input  logic [frontend_pkg::XLEN-1:0]     redirect_pc_i,

    // decoded output
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output frontend_pkg::decoded_t            out_dec_o
);

    import frontend_pkg::*;

    logic                fetch_en;
    logic [XLEN-1:0]     tvec;
    logic                irq_pend;
    logic [IRQ_NO_W-1:0] irq_pend_no;
    logic                irq_take;

    logic [IMEM_AW-1:0]  imem_raddr;
    logic [XLEN-1:0]     imem_rdata;

    logic                fetch_valid;
    logic                fetch_ready;
    fetch_pkt_t          fetch_pkt;

    logic                id_valid;
    logic                id_ready;
    fetch_pkt_t          id_pkt;
    decoded_t            id_dec;

    trap_csr_regs u_csr (
        .clk           (clk),
        .reset         (reset),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .irq_i         (irq_i),
        .irq_no_i      (irq_no_i),
        .irq_take_i    (irq_take),
        .fetch_en_o    (fetch_en),
        .tvec_o        (tvec),
        .irq_pend_o    (irq_pend),
        .irq_pend_no_o (irq_pend_no)
    );

    fetch_pc_gen u_fetch (
        .clk           (clk),
        .reset         (reset),
        .fetch_en_i    (fetch_en),
        .tvec_i        (tvec),
        .irq_pend_i    (irq_pend),
        .irq_pend_no_i (irq_pend_no),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_addr_o   (imem_raddr),
        .instr_i       (imem_rdata),
        .fetch_valid_o (fetch_valid),
        .fetch_ready_i (fetch_ready),
        .fetch_pkt_o   (fetch_pkt),
        .irq_take_o    (irq_take)
    );

    imem_ram u_imem (
        .clk     (clk),
        .we_i    (imem_we_i),
        .waddr_i (imem_addr_i),
        .wdata_i (imem_wdata_i),
        .raddr_i (imem_raddr),
        .rdata_o (imem_rdata)
    );

    // redirect flushes both stages at the same edge
    pipe_stage_reg #(
        .payload_t (fetch_pkt_t)
    ) if_id (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (redirect_i),
        .in_valid_i  (fetch_valid),
        .in_ready_o  (fetch_ready),
        .in_data_i   (fetch_pkt),
        .out_valid_o (id_valid),
        .out_ready_i (id_ready),
        .out_data_o  (id_pkt)
    );

    instr_decode u_dec (
        .pkt_i (id_pkt),
        .dec_o (id_dec)
    );

    pipe_stage_reg #(
        .payload_t (decoded_t)
    ) id_out (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (redirect_i),
        .in_valid_i  (id_valid),
        .in_ready_o  (id_ready),
        .in_data_i   (id_dec),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_dec_o)
    );

endmodule

//--- design/imem_ram.sv
// ****************************************
// instruction word memory, sync write and async read
// ****************************************
module imem_ram (
    input  logic                             clk,

    // load port
    input  logic                             we_i,
    input  logic [frontend_pkg::IMEM_AW-1:0] waddr_i,
    input  logic [frontend_pkg::XLEN-1:0]    wdata_i,

    // fetch port
    input  logic [frontend_pkg::IMEM_AW-1:0] raddr_i,
    output logic [frontend_pkg::XLEN-1:0]    rdata_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // word is back in the same cycle as the address
    assign rdata_o = mem[raddr_i];

endmodule

//--- design/instr_decode.sv
// ****************************************
// RV32I decoder, fetch packet to decoded record
// ****************************************
module instr_decode (
    input  frontend_pkg::fetch_pkt_t pkt_i,
    output frontend_pkg::decoded_t   dec_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] instr;
    logic [4:0]      f_rd;
    logic [4:0]      f_rs1;
    logic [4:0]      f_rs2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign instr = pkt_i.instr;
    assign f_rd  = instr[11:7];
    assign f_rs1 = instr[19:15];
    assign f_rs2 = instr[24:20];

    // immediates per format, sign-extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // fields a format lacks stay zero
        dec_o.pc     = pkt_i.pc;
        dec_o.op     = OP_ILLEGAL;
        dec_o.rd     = '0;
        dec_o.rs1    = '0;
        dec_o.rs2    = '0;
        dec_o.imm    = '0;
        dec_o.irq    = pkt_i.irq;
        dec_o.irq_no = pkt_i.irq_no;

        case (instr[6:0])
            OPC_OP: begin
                dec_o.op  = OP_ALU;
                dec_o.rd  = f_rd;
                dec_o.rs1 = f_rs1;
                dec_o.rs2 = f_rs2;
            end
            OPC_OP_IMM: begin
                dec_o.op  = OP_ALUI;
                dec_o.rd  = f_rd;
                dec_o.rs1 = f_rs1;
                dec_o.imm = imm_i;
            end
            OPC_LOAD: begin
                dec_o.op  = OP_LOAD;
                dec_o.rd  = f_rd;
                dec_o.rs1 = f_rs1;
                dec_o.imm = imm_i;
            end
            OPC_STORE: begin
                dec_o.op  = OP_STORE;
                dec_o.rs1 = f_rs1;
                dec_o.rs2 = f_rs2;
                dec_o.imm = imm_s;
            end
            OPC_BRANCH: begin
                dec_o.op  = OP_BRANCH;
                dec_o.rs1 = f_rs1;
                dec_o.rs2 = f_rs2;
                dec_o.imm = imm_b;
            end
            OPC_JAL: begin
                dec_o.op  = OP_JUMP;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_j;
            end
            OPC_JALR: begin
                dec_o.op  = OP_JUMP;
                dec_o.rd  = f_rd;
                dec_o.rs1 = f_rs1;
                dec_o.imm = imm_i;
            end
            OPC_LUI, OPC_AUIPC: begin
                dec_o.op  = OP_UPPER;
                dec_o.rd  = f_rd;
                dec_o.imm = imm_u;
            end
            default: begin
                // unknown opcode keeps the illegal defaults
                dec_o.op = OP_ILLEGAL;
            end
        endcase
    end

endmodule

//--- design/pipe_stage_reg.sv
// ****************************************
// one-entry valid/ready pipeline register with flush
// ****************************************
module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_i,

    // producer side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    // consumer side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // can take a new entry when empty or when the held one leaves now
    assign in_ready_o  = !valid_q || (valid_q && out_ready_i);
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            // flush wipes the whole entry, payload included
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                data_q <= in_data_i;
            end
        end
        // otherwise hold the stalled entry
    end

endmodule

//--- design/trap_csr_regs.sv
// ****************************************
// fetch control, trap base and pending interrupt latch
// ****************************************
module trap_csr_regs (
    input  logic                              clk,
    input  logic                              reset,

    // configuration write port
    input  logic                              cfg_we_i,
    input  logic [frontend_pkg::CFG_AW-1:0]   cfg_addr_i,
    input  logic [frontend_pkg::XLEN-1:0]     cfg_wdata_i,

    // external interrupt
    input  logic                              irq_i,
    input  logic [frontend_pkg::IRQ_NO_W-1:0] irq_no_i,
    input  logic                              irq_take_i,

    // to the fetch unit
    output logic                              fetch_en_o,
    output logic [frontend_pkg::XLEN-1:0]     tvec_o,
    output logic                              irq_pend_o,
    output logic [frontend_pkg::IRQ_NO_W-1:0] irq_pend_no_o
);

    import frontend_pkg::*;

    logic                fetch_en_q;
    logic                irq_en_q;
    logic [XLEN-1:0]     tvec_q;
    logic                pend_q;
    logic [IRQ_NO_W-1:0] pend_no_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en_q <= 1'b0;
            irq_en_q   <= 1'b0;
            tvec_q     <= '0;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == CFG_ADDR_CTRL) begin
                fetch_en_q <= cfg_wdata_i[CTRL_FETCH_EN_BIT];
                irq_en_q   <= cfg_wdata_i[CTRL_IRQ_EN_BIT];
            end else if (cfg_addr_i == CFG_ADDR_TVEC) begin
                tvec_q <= cfg_wdata_i;
            end
        end
    end

    // one request at a time, held until fetch takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else if (irq_take_i) begin
            pend_q <= 1'b0;
        end else if (irq_i && irq_en_q && !pend_q) begin
            pend_q    <= 1'b1;
            pend_no_q <= irq_no_i;
        end
    end

    assign fetch_en_o    = fetch_en_q;
    assign tvec_o        = tvec_q;
    assign irq_pend_o    = pend_q;
    assign irq_pend_no_o = pend_no_q;

endmodule

//--- files.f
design/frontend_pkg.sv
design/pipe_stage_reg.sv
design/fetch_pc_gen.sv
design/trap_csr_regs.sv
design/imem_ram.sv
design/instr_decode.sv
design/frontend_top.sv
test/frontend_assert.sv
test/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module frontend_tb --Mdir obj_dir -f files.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfrontend_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$SIM_LOG"; then
    echo "no result line found in $SIM_LOG"
    exit 1
fi
exit 0

//--- test/frontend_assert.sv
// ****************************************
// output handshake, flush and reset assertions
// ****************************************
module frontend_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   redirect_i,
    input logic                   out_valid_o,
    input logic                   out_ready_i,
    input frontend_pkg::decoded_t out_dec_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import frontend_pkg::*;

    // a stalled record stays put unless a redirect flushes it
    property stalled_output_holds;
        @(posedge clk) disable iff (reset)
        out_valid_o && !out_ready_i && !redirect_i |=> out_valid_o && $stable(out_dec_o);
    endproperty

    property reset_clears_output;
        @(posedge clk) reset |=> !out_valid_o;
    endproperty

    property redirect_empties_output;
        @(posedge clk) disable iff (reset) redirect_i |=> !out_valid_o;
    endproperty

    property irq_only_when_valid;
        @(posedge clk) disable iff (reset) out_dec_o.irq |-> out_valid_o;
    endproperty

    assert property (stalled_output_holds)
        else $error("decoded output changed while stalled");
    assert property (reset_clears_output)
        else $error("out_valid_o high right after reset");
    assert property (redirect_empties_output)
        else $error("out_valid_o high right after a redirect");
    assert property (irq_only_when_valid)
        else $error("irq flag seen without out_valid_o");

endmodule

bind frontend_top frontend_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .redirect_i  (redirect_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_dec_o   (out_dec_o)
);

//--- test/frontend_tb.sv
// ****************************************
// front end testbench: decode table, back-pressure, redirect,
// interrupts, fetch disable
// ****************************************
module frontend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import frontend_pkg::*;

    localparam int              TABLE_LEN = 16;
    localparam int              NUM_TESTS = 4;
    localparam int              WATCHDOG_CYCLES = NUM_TESTS * TABLE_LEN * 20 + IMEM_DEPTH + 200;
    localparam logic [XLEN-1:0] REDIR_PC  = 32'h24;
    localparam logic [XLEN-1:0] TRAP_BASE = 32'h20;
    localparam logic [7:0]      IRQ_NUM   = 8'd3;

    logic                clk;
    logic                reset;
    logic                cfg_we_i;
    logic [CFG_AW-1:0]   cfg_addr_i;
    logic [XLEN-1:0]     cfg_wdata_i;
    logic                imem_we_i;
    logic [IMEM_AW-1:0]  imem_addr_i;
    logic [XLEN-1:0]     imem_wdata_i;
    logic                irq_i;
    logic [IRQ_NO_W-1:0] irq_no_i;
    logic                redirect_i;
    logic [XLEN-1:0]     redirect_pc_i;
    logic                out_ready_i = 1'b0;
    logic                out_valid_o;
    decoded_t            out_dec_o;

    // stimulus table, pc of a row is 4 * index
    string           row_name  [TABLE_LEN];
    logic [XLEN-1:0] row_instr [TABLE_LEN];
    op_class_e       row_op    [TABLE_LEN];
    logic [4:0]      row_rd    [TABLE_LEN];
    logic [4:0]      row_rs1   [TABLE_LEN];
    logic [4:0]      row_rs2   [TABLE_LEN];
    logic [XLEN-1:0] row_imm   [TABLE_LEN];

    decoded_t        rx_q[$];
    int              rx_base = 0;
    logic [31:0]     lfsr_q = 32'd81399;
    bit              rand_ready = 1'b0;
    int              errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    int              test_err_base = 0;
    int              split;

    frontend_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .irq_i         (irq_i),
        .irq_no_i      (irq_no_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_dec_o     (out_dec_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    always @(posedge clk) begin
        if (rand_ready) begin
            lfsr_q = lfsr_next(lfsr_q);
            out_ready_i <= lfsr_q[0];
        end else begin
            out_ready_i <= 1'b1;
        end
    end

    // scoreboard input, every transferred record
    always @(posedge clk) begin
        if (out_valid_o && out_ready_i) begin
            rx_q.push_back(out_dec_o);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic set_row(input int i, input string name, input logic [31:0] instr,
                           input op_class_e op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] imm);
        row_name[i]  = name;
        row_instr[i] = instr;
        row_op[i]    = op;
        row_rd[i]    = rd;
        row_rs1[i]   = rs1;
        row_rs2[i]   = rs2;
        row_imm[i]   = imm;
    endtask

    // words past the table have opcode 0, so they decode as illegal
    function automatic logic [31:0] fill_word(input int a);
        logic [5:0] w;
        w = a[5:0];
        return {w, ~w, w, ~w, 1'b1, 7'b0000000};
    endfunction

    function automatic decoded_t expected_for(input logic [31:0] pc);
        decoded_t d;
        int       idx;
        d    = '0;
        d.pc = pc;
        d.op = OP_ILLEGAL;
        idx  = int'(pc >> 2);
        if (idx < TABLE_LEN) begin
            d.op  = row_op[idx];
            d.rd  = row_rd[idx];
            d.rs1 = row_rs1[idx];
            d.rs2 = row_rs2[idx];
            d.imm = row_imm[idx];
        end
        return d;
    endfunction

    function automatic string row_label(input logic [31:0] pc);
        int idx;
        idx = int'(pc >> 2);
        return (idx < TABLE_LEN) ? row_name[idx] : "fill";
    endfunction

    function automatic int received();
        return rx_q.size() - rx_base;
    endfunction

    task automatic compare_word(input string name, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    task automatic compare_op(input string name, input op_class_e exp, input op_class_e act);
        if (act !== exp) begin
            errors++;
            $display("Error: %s op expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic compare_dec(input string name, input decoded_t exp, input decoded_t act);
        compare_word(name, "pc", exp.pc, act.pc);
        compare_op(name, exp.op, act.op);
        compare_word(name, "rd", 32'(exp.rd), 32'(act.rd));
        compare_word(name, "rs1", 32'(exp.rs1), 32'(act.rs1));
        compare_word(name, "rs2", 32'(exp.rs2), 32'(act.rs2));
        compare_word(name, "imm", exp.imm, act.imm);
        compare_word(name, "irq", 32'(exp.irq), 32'(act.irq));
        compare_word(name, "irq_no", 32'(exp.irq_no), 32'(act.irq_no));
    endtask

    task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [XLEN-1:0] data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] pc);
        @(posedge clk);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk);
        redirect_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic pulse_irq(input logic [IRQ_NO_W-1:0] num);
        @(posedge clk);
        irq_i    <= 1'b1;
        irq_no_i <= num;
        @(posedge clk);
        irq_i    <= 1'b0;
        irq_no_i <= '0;
        @(negedge clk);
    endtask

    // gives up after 16 cycles per wanted record, a shortfall is reported later
    task automatic wait_records(input int n);
        int cycles;
        cycles = 0;
        while (received() < n && cycles < n * 16) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    // clear fetch enable, then count what is still in flight
    task automatic stop_fetch(input string test);
        int base;
        int late;
        int stuck;
        rand_ready = 1'b0;
        cfg_write(CFG_ADDR_CTRL, 32'h0);
        base = rx_q.size();
        repeat (4) @(negedge clk);
        if (rx_q.size() - base > 2) begin
            errors++;
            $display("%s: %0d records arrived after fetch was disabled, at most 2 allowed",
                     test, rx_q.size() - base);
        end
        late  = rx_q.size();
        stuck = 0;
        repeat (8) begin
            @(negedge clk);
            if (out_valid_o) stuck++;
        end
        if (stuck != 0 || rx_q.size() != late) begin
            errors++;
            $display("%s: out_valid_o did not stay low after fetch was disabled", test);
        end
    endtask

    task automatic check_stream(input string test, input logic [31:0] start_pc,
                                input int split_idx, input logic [31:0] split_pc,
                                input bit irq_on, input logic [7:0] irq_no,
                                input logic [31:0] vec_pc, input int min_records);
        decoded_t    exp;
        decoded_t    act;
        logic [31:0] exp_pc;
        int          tags;
        exp_pc = start_pc;
        tags   = 0;
        if (received() < min_records) begin
            errors++;
            $display("%s: only %0d records arrived, %0d were due", test, received(), min_records);
        end
        for (int i = 0; i < received(); i++) begin
            act = rx_q[rx_base + i];
            if (i == split_idx) exp_pc = split_pc;
            exp = expected_for(exp_pc);
            if (irq_on && act.irq && tags == 0) begin
                exp.irq    = 1'b1;
                exp.irq_no = irq_no;
            end
            compare_dec($sformatf("%s/%s", test, row_label(exp_pc)), exp, act);
            if (act.irq) tags++;
            // a tagged fetch sends the pc to the trap vector
            exp_pc = exp.irq ? vec_pc : exp_pc + 32'd4;
        end
        if (irq_on && tags != 1) begin
            errors++;
            $display("%s: expected exactly one interrupt-tagged record, saw %0d", test, tags);
        end
    endtask

    task automatic begin_test(input logic [XLEN-1:0] pc);
        redirect_to(pc);
        rx_base       = rx_q.size();
        test_err_base = errors;
    endtask

    task automatic end_test(input string test);
        tests_run++;
        if (errors != test_err_base) tests_failed++;
        $display("test %-16s %0d records, %0d errors", test, received(), errors - test_err_base);
    endtask

    initial begin
        reset         = 1'b1;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = '0;
        cfg_wdata_i   = '0;
        imem_we_i     = 1'b0;
        imem_addr_i   = '0;
        imem_wdata_i  = '0;
        irq_i         = 1'b0;
        irq_no_i      = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;

        set_row(0,  "add",     32'h002081B3, OP_ALU,     5'd3,  5'd1,  5'd2,  32'h0000_0000);
        set_row(1,  "sub",     32'h407302B3, OP_ALU,     5'd5,  5'd6,  5'd7,  32'h0000_0000);
        set_row(2,  "addi",    32'hFFF00093, OP_ALUI,    5'd1,  5'd0,  5'd0,  32'hFFFF_FFFF);
        set_row(3,  "xori",    32'h05514213, OP_ALUI,    5'd4,  5'd2,  5'd0,  32'h0000_0055);
        set_row(4,  "lw",      32'h00812303, OP_LOAD,    5'd6,  5'd2,  5'd0,  32'h0000_0008);
        set_row(5,  "lb",      32'hFFC18383, OP_LOAD,    5'd7,  5'd3,  5'd0,  32'hFFFF_FFFC);
        set_row(6,  "sw",      32'h0050A623, OP_STORE,   5'd0,  5'd1,  5'd5,  32'h0000_000C);
        set_row(7,  "sh",      32'hFE821F23, OP_STORE,   5'd0,  5'd4,  5'd8,  32'hFFFF_FFFE);
        set_row(8,  "beq",     32'h00208863, OP_BRANCH,  5'd0,  5'd1,  5'd2,  32'h0000_0010);
        set_row(9,  "bne",     32'hFE419CE3, OP_BRANCH,  5'd0,  5'd3,  5'd4,  32'hFFFF_FFF8);
        set_row(10, "jal",     32'h001000EF, OP_JUMP,    5'd1,  5'd0,  5'd0,  32'h0000_0800);
        set_row(11, "jalr",    32'h00408067, OP_JUMP,    5'd0,  5'd1,  5'd0,  32'h0000_0004);
        set_row(12, "lui",     32'h12345537, OP_UPPER,   5'd10, 5'd0,  5'd0,  32'h1234_5000);
        set_row(13, "auipc",   32'hFFFFF597, OP_UPPER,   5'd11, 5'd0,  5'd0,  32'hFFFF_F000);
        set_row(14, "illegal", 32'hFFFFFFFF, OP_ILLEGAL, 5'd0,  5'd0,  5'd0,  32'h0000_0000);
        set_row(15, "add_hi",  32'h01DF0FB3, OP_ALU,     5'd31, 5'd30, 5'd29, 32'h0000_0000);

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // whole memory, table first
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= IMEM_AW'(a);
            imem_wdata_i <= (a < TABLE_LEN) ? row_instr[a] : fill_word(a);
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        @(negedge clk);

        begin_test(RESET_PC);
        rand_ready = 1'b1;
        cfg_write(CFG_ADDR_CTRL, 32'h1);
        wait_records(TABLE_LEN);
        stop_fetch("straight_decode");
        check_stream("straight_decode", RESET_PC, -1, '0, 1'b0, '0, '0, TABLE_LEN);
        end_test("straight_decode");

        begin_test(RESET_PC);
        rand_ready = 1'b1;
        cfg_write(CFG_ADDR_CTRL, 32'h1);
        wait_records(4);
        redirect_to(REDIR_PC);
        split = received();
        wait_records(split + 8);
        stop_fetch("redirect");
        check_stream("redirect", RESET_PC, split, REDIR_PC, 1'b0, '0, '0, split + 8);
        end_test("redirect");

        begin_test(RESET_PC);
        cfg_write(CFG_ADDR_TVEC, TRAP_BASE);
        rand_ready = 1'b1;
        cfg_write(CFG_ADDR_CTRL, 32'h3);
        wait_records(3);
        pulse_irq(IRQ_NUM);
        wait_records(16);
        stop_fetch("irq_enabled");
        check_stream("irq_enabled", RESET_PC, -1, '0, 1'b1, IRQ_NUM,
                     TRAP_BASE + {22'd0, IRQ_NUM, 2'b00}, 16);
        end_test("irq_enabled");

        // enable bit clear, the request must be ignored
        begin_test(RESET_PC);
        rand_ready = 1'b1;
        cfg_write(CFG_ADDR_CTRL, 32'h1);
        wait_records(3);
        pulse_irq(IRQ_NUM);
        wait_records(12);
        stop_fetch("irq_masked");
        check_stream("irq_masked", RESET_PC, -1, '0, 1'b0, '0, '0, 12);
        end_test("irq_masked");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
